//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int WORD_BITS = 16; // data and byte-address width
	localparam int BYTE_BITS = 8;  // one byte lane of a word
	localparam int IMM_BITS  = 13; // address or immediate field in the low bits of an instruction
	localparam int OPC_LSB   = 13; // opcode sits in bits 15 down to 13

	// argument cycle that follows DECODE
	typedef enum logic [2:0] {
		BUS_SEQX_IDLE  = 3'd0, // no argument access in COMMIT
		BUS_SEQX_ARGRD = 3'd1, // argument read in COMMIT
		BUS_SEQX_ARGWR = 3'd2  // argument write in COMMIT
	} busSeqT;

	typedef enum logic {
		DEBUG_DATA_SELX_OP  = 1'b0, // debug port returns the injected instruction word
		DEBUG_DATA_SELX_ARG = 1'b1  // debug port returns its argument register
	} debugDataSelT;

	typedef enum logic [2:0] {
		OP_NOP = 3'd0, // nothing happens apart from the PC step
		OP_LDW = 3'd1, // accumulator gets the word at the address
		OP_STW = 3'd2, // accumulator word goes to the address
		OP_STB = 3'd3, // low accumulator byte goes to the byte address
		OP_LDI = 3'd4, // accumulator gets the zero-extended immediate
		OP_JMP = 3'd5  // PC gets the address
	} opcodeT;

	typedef enum logic [1:0] {
		HOST_CTRL   = 2'd0, // stop, debug and step control plus ring status
		HOST_OPCODE = 2'd1, // instruction word injected while debugging
		HOST_ARG    = 2'd2, // argument data for debug reads, captured on debug writes
		HOST_ADDR   = 2'd3  // address shown on the pins while debugging
	} hostRegT;

	// bit positions inside HOST_CTRL
	localparam int CTRL_STOP_BIT  = 0; // halt at the next instruction boundary
	localparam int CTRL_DEBUG_BIT = 1; // take instructions and data from the debug port
	localparam int CTRL_STEP_BIT  = 2; // write only, releases one instruction
	localparam int CTRL_IDLE_BIT  = 3; // read only, ring is parked with no phase high

endpackage

`default_nettype wire

//--- logic/coreSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module coreSequencer import cpuPkg::*; #(
	parameter logic [WORD_BITS-1:0] RESET_PC = '0 // byte address of the first fetch
) (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire logic                 DEBUG_STOP, // hold at the next instruction boundary
	input  wire logic                 debugStep,  // one-cycle request for a single instruction
	input  wire logic [WORD_BITS-1:0] CPU_DIN,    // read data from the bus interface
	output logic                      FETCH,
	output logic                      DECODE,
	output logic                      EXECUTE,
	output logic                      COMMIT,
	output busSeqT                    BUS_SEQX,   // argument cycle of the current instruction
	output logic      [WORD_BITS-1:0] CPU_ADDR,
	output logic      [WORD_BITS-1:0] CPU_DOUT,
	output logic                      CPU_BYTEX   // current store is a single byte
);

	logic [3:0]           phaseQ;      // one-hot ring, bit 0 is FETCH and all zero means idle
	logic                 atBoundary;  // last cycle of an instruction or parked between them
	logic                 runNext;     // next instruction may start
	logic                 stepPending; // a step arrived while an instruction was in flight
	logic [WORD_BITS-1:0] pc;
	logic [WORD_BITS-1:0] instr;
	logic [WORD_BITS-1:0] acc;
	logic [WORD_BITS-1:0] argField;    // low field of the instruction, zero-extended
	opcodeT               opcode;

	assign FETCH   = phaseQ[0];
	assign DECODE  = phaseQ[1];
	assign EXECUTE = phaseQ[2];
	assign COMMIT  = phaseQ[3];

	assign atBoundary = COMMIT | (phaseQ == 4'b0000);
	assign runNext    = ~DEBUG_STOP | stepPending | debugStep; // a step in COMMIT itself counts too

	// Phase ring with the stop/step gate at the instruction boundary
	always_ff @(posedge CLK) begin
		if (RESET) begin
			phaseQ      <= 4'b0001; // come out of reset in FETCH
			stepPending <= 1'b0;
		end else begin
			if (atBoundary) begin
				phaseQ      <= runNext ? 4'b0001 : 4'b0000; // park with no phase high when held
				stepPending <= 1'b0;                        // any pending step is used up here
			end else begin
				phaseQ      <= {phaseQ[2:0], 1'b0};
				stepPending <= stepPending | debugStep; // remember it until the boundary
			end
		end
	end

	assign opcode   = opcodeT'(instr[WORD_BITS-1:OPC_LSB]);
	assign argField = {{(WORD_BITS-IMM_BITS){1'b0}}, instr[IMM_BITS-1:0]};

	// PC drives the bus for the fetch and the argument address takes over from EXECUTE
	assign CPU_ADDR  = (EXECUTE | COMMIT) ? argField : pc;
	assign CPU_DOUT  = acc;
	assign CPU_BYTEX = (opcode == OP_STB);

	// Instruction register and bus sequence are loaded at the end of DECODE
	always_ff @(posedge CLK) begin
		if (RESET) begin
			instr    <= '0; // decodes as OP_NOP
			BUS_SEQX <= BUS_SEQX_IDLE;
		end else begin
			if (DECODE) begin
				instr <= CPU_DIN;
				case (opcodeT'(CPU_DIN[WORD_BITS-1:OPC_LSB]))
					OP_LDW: begin
						BUS_SEQX <= BUS_SEQX_ARGRD; // word comes back in COMMIT
					end
					OP_STW, OP_STB: begin
						BUS_SEQX <= BUS_SEQX_ARGWR; // lanes are picked by the bus interface
					end
					OP_NOP, OP_LDI, OP_JMP: begin
						BUS_SEQX <= BUS_SEQX_IDLE;
					end
					default: begin
						BUS_SEQX <= BUS_SEQX_IDLE; // unused codes behave as a NOP
					end
				endcase
			end else if (COMMIT) begin
				BUS_SEQX <= BUS_SEQX_IDLE; // sequence only holds over EXECUTE and COMMIT
			end
		end
	end

	// Accumulator and PC are updated at the end of COMMIT
	always_ff @(posedge CLK) begin
		if (RESET) begin
			pc  <= RESET_PC;
			acc <= '0;
		end else begin
			if (COMMIT) begin
				case (opcode)
					OP_LDW: begin
						acc <= CPU_DIN; // read data is valid for the whole COMMIT cycle
					end
					OP_LDI: begin
						acc <= argField;
					end
					default: begin
						acc <= acc;
					end
				endcase
				if (opcode == OP_JMP) begin
					pc <= argField;
				end else begin
					pc <= pc + WORD_BITS'(2); // instructions are one word apart
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/busInterface.sv
`timescale 1ns/1ns
`default_nettype none

module busInterface import cpuPkg::*; (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire logic                 FETCH,
	input  wire logic                 EXECUTE,
	input  wire busSeqT               BUS_SEQX,
	input  wire logic [WORD_BITS-1:0] CPU_ADDR,
	input  wire logic [WORD_BITS-1:0] CPU_DOUT,
	input  wire logic                 CPU_BYTEX,
	output logic      [WORD_BITS-1:0] CPU_DIN,
	output logic                      RD_BUF,          // high for all of DECODE or COMMIT
	output logic                      WR0_BUF,         // low byte lane
	output logic                      WR1_BUF,         // high byte lane
	output logic      [WORD_BITS-1:0] ADDR_BUF,
	output logic      [WORD_BITS-1:0] DOUT_BUF,
	input  wire logic [WORD_BITS-1:0] DIN_BUF,         // combinational read data from memory
	input  wire logic                 DEBUG_STOP,
	input  wire logic                 DEBUG_DEBUG,
	output logic                      DEBUG_RD,
	output logic                      DEBUG_WR,
	output debugDataSelT              DEBUG_DATA_SELX,
	output logic      [WORD_BITS-1:0] DEBUG_DIN,       // accumulator held for a debug capture
	input  wire logic [WORD_BITS-1:0] DEBUG_DOUT,
	input  wire logic [WORD_BITS-1:0] DEBUG_ADDR
);

	logic debugging; // the debug port stands in for memory
	logic highByte;  // byte store to an odd address
	logic argRead;   // EXECUTE of an instruction whose argument is read in COMMIT
	logic argWrite;  // EXECUTE of an instruction whose argument is written in COMMIT
	logic busRead;   // the next cycle is a read cycle

	assign debugging = DEBUG_STOP & DEBUG_DEBUG;
	assign highByte  = CPU_BYTEX & CPU_ADDR[0];
	assign argRead   = EXECUTE & (BUS_SEQX == BUS_SEQX_ARGRD);
	assign argWrite  = EXECUTE & (BUS_SEQX == BUS_SEQX_ARGWR);
	assign busRead   = FETCH | argRead; // the fetch read always happens

	// Address and data paths switch over to the debug port while debugging
	assign CPU_DIN  = debugging ? DEBUG_DOUT : DIN_BUF;
	assign ADDR_BUF = debugging ? DEBUG_ADDR : CPU_ADDR;
	assign DOUT_BUF = highByte ? {CPU_DOUT[BYTE_BITS-1:0], BYTE_BITS'(0)} : CPU_DOUT;

	// reads are registered one phase early so they cover the whole DECODE or COMMIT
	always_ff @(posedge CLK) begin
		if (RESET) begin
			RD_BUF   <= 1'b0;
			DEBUG_RD <= 1'b0;
		end else begin
			RD_BUF   <= busRead & ~debugging;
			DEBUG_RD <= busRead &  debugging;
		end
	end

	// writes land in COMMIT, lane enables follow the byte address
	always_ff @(posedge CLK) begin
		if (RESET) begin
			WR0_BUF         <= 1'b0;
			WR1_BUF         <= 1'b0;
			DEBUG_WR        <= 1'b0;
			DEBUG_DATA_SELX <= DEBUG_DATA_SELX_OP;
		end else begin
			WR0_BUF  <= argWrite & ~debugging & (~CPU_BYTEX | ~CPU_ADDR[0]); // even byte or word
			WR1_BUF  <= argWrite & ~debugging & (~CPU_BYTEX |  CPU_ADDR[0]); // odd byte or word
			DEBUG_WR <= argWrite &  debugging;
			if (debugging & (argRead | argWrite)) begin
				DEBUG_DATA_SELX <= DEBUG_DATA_SELX_ARG; // argument register serves the COMMIT
			end else begin
				DEBUG_DATA_SELX <= DEBUG_DATA_SELX_OP;  // instruction word for the next fetch
			end
		end
	end

	// data for the debug port is taken with the write strobe
	always_ff @(posedge CLK) begin
		if (argWrite) begin
			DEBUG_DIN <= CPU_DOUT;
		end
	end

endmodule

`default_nettype wire

//--- logic/debugPort.sv
`timescale 1ns/1ns
`default_nettype none

module debugPort import cpuPkg::*; (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire logic                 hostWrite,       // one-cycle write strobe from the host
	input  wire hostRegT              hostReg,
	input  wire logic [WORD_BITS-1:0] hostWdata,
	output logic      [WORD_BITS-1:0] hostRdata,       // follows hostReg without a clock
	input  wire logic                 DEBUG_RD,
	input  wire logic                 DEBUG_WR,
	input  wire debugDataSelT         DEBUG_DATA_SELX,
	input  wire logic [WORD_BITS-1:0] DEBUG_DIN,
	input  wire logic                 idle,            // ring parked between instructions
	output logic                      DEBUG_STOP,
	output logic                      DEBUG_DEBUG,
	output logic                      debugStep,
	output logic      [WORD_BITS-1:0] DEBUG_DOUT,
	output logic      [WORD_BITS-1:0] DEBUG_ADDR
);

	logic                 ctrlWrite;  // host write to HOST_CTRL
	logic [WORD_BITS-1:0] opcodeReg;  // whole instruction word handed out on a debug fetch
	logic [WORD_BITS-1:0] argReg;
	logic [WORD_BITS-1:0] addrReg;
	logic [WORD_BITS-1:0] ctrlStatus; // HOST_CTRL as the host reads it back

	assign ctrlWrite = hostWrite & (hostReg == HOST_CTRL);

	// stop and debug are levels, step is a pulse lasting a single cycle
	always_ff @(posedge CLK) begin
		if (RESET) begin
			DEBUG_STOP  <= 1'b0;
			DEBUG_DEBUG <= 1'b0;
			debugStep   <= 1'b0;
		end else begin
			if (ctrlWrite) begin
				DEBUG_STOP  <= hostWdata[CTRL_STOP_BIT];
				DEBUG_DEBUG <= hostWdata[CTRL_DEBUG_BIT];
			end
			debugStep <= ctrlWrite & hostWdata[CTRL_STEP_BIT];
		end
	end

	// Data registers loaded by the host
	always_ff @(posedge CLK) begin
		if (hostWrite && (hostReg == HOST_OPCODE)) begin
			opcodeReg <= hostWdata;
		end
		if (hostWrite && (hostReg == HOST_ADDR)) begin
			addrReg <= hostWdata;
		end
		if (DEBUG_WR) begin
			argReg <= DEBUG_DIN; // capture of a debug store wins over the host
		end else if (hostWrite && (hostReg == HOST_ARG)) begin
			argReg <= hostWdata;
		end
	end

	assign DEBUG_ADDR = addrReg;

	// data is only put out while the CPU is reading from the port
	always_comb begin
		if (!DEBUG_RD) begin
			DEBUG_DOUT = '0;
		end else if (DEBUG_DATA_SELX == DEBUG_DATA_SELX_ARG) begin
			DEBUG_DOUT = argReg;
		end else begin
			DEBUG_DOUT = opcodeReg;
		end
	end

	always_comb begin
		ctrlStatus                 = '0;
		ctrlStatus[CTRL_STOP_BIT]  = DEBUG_STOP;
		ctrlStatus[CTRL_DEBUG_BIT] = DEBUG_DEBUG;
		ctrlStatus[CTRL_IDLE_BIT]  = idle; // step bit reads back as zero
	end

	always_comb begin
		case (hostReg)
			HOST_CTRL:   hostRdata = ctrlStatus;
			HOST_OPCODE: hostRdata = opcodeReg;
			HOST_ARG:    hostRdata = argReg;
			HOST_ADDR:   hostRdata = addrReg;
			default:     hostRdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cpuSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module cpuSubsystem import cpuPkg::*; #(
	parameter logic [WORD_BITS-1:0] RESET_PC = '0 // first fetch address, handed to the core
) (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire logic [WORD_BITS-1:0] DIN_BUF,
	output logic      [WORD_BITS-1:0] ADDR_BUF,
	output logic      [WORD_BITS-1:0] DOUT_BUF,
	output logic                      RD_BUF,
	output logic                      WR0_BUF,
	output logic                      WR1_BUF,
	input  wire logic                 hostWrite,
	input  wire hostRegT              hostReg,
	input  wire logic [WORD_BITS-1:0] hostWdata,
	output logic      [WORD_BITS-1:0] hostRdata
);

	logic                 fetch;
	logic                 decode;
	logic                 execute;
	logic                 commit;
	logic                 idle;       // no phase high, the ring waits for a run or a step
	busSeqT               busSeq;
	logic [WORD_BITS-1:0] cpuAddr;
	logic [WORD_BITS-1:0] cpuDout;
	logic [WORD_BITS-1:0] cpuDin;
	logic                 cpuByte;
	logic                 debugStop;  // shared by the core gate and the bus switch-over
	logic                 debugDebug;
	logic                 debugStep;
	logic                 debugRd;
	logic                 debugWr;
	debugDataSelT         debugSel;
	logic [WORD_BITS-1:0] debugDin;
	logic [WORD_BITS-1:0] debugDout;
	logic [WORD_BITS-1:0] debugAddr;

	assign idle = ~(fetch | decode | execute | commit);

	coreSequencer #(
		.RESET_PC(RESET_PC)
	) coreSequencer_i (
		.CLK       (CLK),
		.RESET     (RESET),
		.DEBUG_STOP(debugStop),
		.debugStep (debugStep),
		.CPU_DIN   (cpuDin),
		.FETCH     (fetch),
		.DECODE    (decode),
		.EXECUTE   (execute),
		.COMMIT    (commit),
		.BUS_SEQX  (busSeq),
		.CPU_ADDR  (cpuAddr),
		.CPU_DOUT  (cpuDout),
		.CPU_BYTEX (cpuByte)
	);

	busInterface busInterface_i (
		.CLK            (CLK),
		.RESET          (RESET),
		.FETCH          (fetch),
		.EXECUTE        (execute),
		.BUS_SEQX       (busSeq),
		.CPU_ADDR       (cpuAddr),
		.CPU_DOUT       (cpuDout),
		.CPU_BYTEX      (cpuByte),
		.CPU_DIN        (cpuDin),
		.RD_BUF         (RD_BUF),
		.WR0_BUF        (WR0_BUF),
		.WR1_BUF        (WR1_BUF),
		.ADDR_BUF       (ADDR_BUF),
		.DOUT_BUF       (DOUT_BUF),
		.DIN_BUF        (DIN_BUF),
		.DEBUG_STOP     (debugStop),
		.DEBUG_DEBUG    (debugDebug),
		.DEBUG_RD       (debugRd),
		.DEBUG_WR       (debugWr),
		.DEBUG_DATA_SELX(debugSel),
		.DEBUG_DIN      (debugDin),
		.DEBUG_DOUT     (debugDout),
		.DEBUG_ADDR     (debugAddr)
	);

	debugPort debugPort_i (
		.CLK            (CLK),
		.RESET          (RESET),
		.hostWrite      (hostWrite),
		.hostReg        (hostReg),
		.hostWdata      (hostWdata),
		.hostRdata      (hostRdata),
		.DEBUG_RD       (debugRd),
		.DEBUG_WR       (debugWr),
		.DEBUG_DATA_SELX(debugSel),
		.DEBUG_DIN      (debugDin),
		.idle           (idle),
		.DEBUG_STOP     (debugStop),
		.DEBUG_DEBUG    (debugDebug),
		.debugStep      (debugStep),
		.DEBUG_DOUT     (debugDout),
		.DEBUG_ADDR     (debugAddr)
	);

endmodule

`default_nettype wire

//--- verif/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// every row kind treats addr as a byte address
localparam logic [3:0] K_LOAD    = 4'd0; // preload one memory word with data or with random data
localparam logic [3:0] K_HWR     = 4'd1; // host write of hreg with data
localparam logic [3:0] K_RUNTO   = 4'd2; // clear stop and run until the fetch at addr
localparam logic [3:0] K_STOP    = 4'd3; // set stop and wait for the ring to park
localparam logic [3:0] K_STEP    = 4'd4; // one step with the current debug level
localparam logic [3:0] K_QUIET   = 4'd5; // data cycles with no bus activity at all
localparam logic [3:0] K_EXPMEM  = 4'd6; // memory word at addr against the model
localparam logic [3:0] K_EXPHOST = 4'd7; // hostRdata of hreg against the model

typedef struct packed {
	logic [3:0]  kind;
	logic [3:0]  test;
	hostRegT     hreg;
	logic [15:0] addr;
	logic [15:0] data;
	logic        rnd;
} rowT;

localparam int ROW_COUNT = 49;

localparam rowT PROGRAM_TABLE [ROW_COUNT] = '{
	'{K_STOP,    4'd2, HOST_CTRL,   16'h0000, 16'h0000, 1'b0}, // park the reset loop at 0
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0300, 16'h0000, 1'b1},
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0000, {OP_LDI, 13'h0123}, 1'b0},
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0002, {OP_STW, 13'h0200}, 1'b0},
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0004, {OP_LDW, 13'h0300}, 1'b0},
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0006, {OP_STW, 13'h0202}, 1'b0},
	'{K_LOAD,    4'd2, HOST_CTRL,   16'h0008, {OP_JMP, 13'h0010}, 1'b0},
	'{K_RUNTO,   4'd2, HOST_CTRL,   16'h0010, 16'h0000, 1'b0}, // 0x10 holds its fill jump
	'{K_STOP,    4'd2, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd2, HOST_CTRL,   16'h0200, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd2, HOST_CTRL,   16'h0202, 16'h0000, 1'b0},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0400, 16'h0000, 1'b1},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0500, 16'h0000, 1'b1},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0502, 16'h0000, 1'b1},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0010, {OP_LDW, 13'h0400}, 1'b0},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0012, {OP_STB, 13'h0500}, 1'b0},
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0014, {OP_STB, 13'h0503}, 1'b0}, // odd lane
	'{K_LOAD,    4'd3, HOST_CTRL,   16'h0016, {OP_JMP, 13'h0020}, 1'b0},
	'{K_RUNTO,   4'd3, HOST_CTRL,   16'h0020, 16'h0000, 1'b0},
	'{K_STOP,    4'd3, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd3, HOST_CTRL,   16'h0500, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd3, HOST_CTRL,   16'h0502, 16'h0000, 1'b0},
	'{K_QUIET,   4'd4, HOST_CTRL,   16'h0000, 16'd20,   1'b0},
	'{K_LOAD,    4'd4, HOST_CTRL,   16'h0020, {OP_LDI, 13'h0777}, 1'b0},
	'{K_LOAD,    4'd4, HOST_CTRL,   16'h0022, {OP_STW, 13'h0600}, 1'b0},
	'{K_LOAD,    4'd4, HOST_CTRL,   16'h0024, {OP_LDI, 13'h0055}, 1'b0},
	'{K_LOAD,    4'd4, HOST_CTRL,   16'h0026, {OP_STW, 13'h0602}, 1'b0},
	'{K_LOAD,    4'd4, HOST_CTRL,   16'h0028, {OP_JMP, 13'h0030}, 1'b0},
	'{K_EXPHOST, 4'd4, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_STEP,    4'd4, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_STEP,    4'd4, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd4, HOST_CTRL,   16'h0600, 16'h0000, 1'b0},
	'{K_RUNTO,   4'd4, HOST_CTRL,   16'h0030, 16'h0000, 1'b0},
	'{K_STOP,    4'd4, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_HWR,     4'd5, HOST_ADDR,   16'h0000, 16'h0700, 1'b0},
	'{K_HWR,     4'd5, HOST_OPCODE, 16'h0000, {OP_LDI, 13'h0abc}, 1'b0},
	'{K_HWR,     4'd5, HOST_CTRL,   16'h0000, 16'h0003, 1'b0}, // stop with debug
	'{K_EXPHOST, 4'd5, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_STEP,    4'd5, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_HWR,     4'd5, HOST_OPCODE, 16'h0000, {OP_STW, 13'h0700}, 1'b0},
	'{K_STEP,    4'd5, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_EXPHOST, 4'd5, HOST_ARG,    16'h0000, 16'h0000, 1'b0},
	'{K_HWR,     4'd5, HOST_ARG,    16'h0000, 16'h0000, 1'b1},
	'{K_HWR,     4'd5, HOST_OPCODE, 16'h0000, {OP_LDW, 13'h0700}, 1'b0},
	'{K_STEP,    4'd5, HOST_CTRL,   16'h0000, 16'h0000, 1'b0},
	'{K_LOAD,    4'd5, HOST_CTRL,   16'h0036, {OP_STW, 13'h0710}, 1'b0}, // stores the injected load
	'{K_LOAD,    4'd5, HOST_CTRL,   16'h0038, {OP_JMP, 13'h0040}, 1'b0},
	'{K_RUNTO,   4'd5, HOST_CTRL,   16'h0040, 16'h0000, 1'b0},
	'{K_EXPMEM,  4'd5, HOST_CTRL,   16'h0710, 16'h0000, 1'b0}
};

`endif

//--- verif/cpuSubsystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuSubsystemTb import cpuPkg::*; ();

	logic        CLK = 1'b0;
	logic        RESET;
	logic [15:0] DIN_BUF;
	logic [15:0] ADDR_BUF;
	logic [15:0] DOUT_BUF;
	logic        RD_BUF;
	logic        WR0_BUF;
	logic        WR1_BUF;
	logic        hostWrite;
	hostRegT     hostReg;
	logic [15:0] hostWdata;
	logic [15:0] hostRdata;
	logic        loadEn;   // preload port into the memory model
	logic [15:0] loadAddr;
	logic [15:0] loadData;

	logic [15:0] mem [4096];
	logic [15:0] shadow [4096]; // memory as the reference model predicts it

	`include "programTable.svh"

	typedef struct packed {
		logic [15:0] addr;
		logic        rd;
		logic        wr0;
		logic        wr1;
		logic [15:0] data;
		logic [15:0] mask; // lanes of DOUT_BUF that carry the store
	} busEventT;

	busEventT    expQ [$]; // pin cycles the model expects, in order
	logic [15:0] mPc;
	logic [15:0] mAcc;
	logic [15:0] mOpcode;
	logic [15:0] mArg;
	logic [15:0] mAddr;
	logic        mStop;
	logic        mDebug;
	int          checkCount;
	int          errorCount;
	bit          timedOut;

	cpuSubsystem #(
		.RESET_PC(16'h0000)
	) cpuSubsystem_i (
		.CLK      (CLK),
		.RESET    (RESET),
		.DIN_BUF  (DIN_BUF),
		.ADDR_BUF (ADDR_BUF),
		.DOUT_BUF (DOUT_BUF),
		.RD_BUF   (RD_BUF),
		.WR0_BUF  (WR0_BUF),
		.WR1_BUF  (WR1_BUF),
		.hostWrite(hostWrite),
		.hostReg  (hostReg),
		.hostWdata(hostWdata),
		.hostRdata(hostRdata)
	);

	always #20 CLK = ~CLK; // 40 ns period

	assign DIN_BUF = mem[ADDR_BUF[12:1]]; // zero-wait combinational read

	always @(posedge CLK) begin
		if (RESET) begin
			for (int i = 0; i < 4096; i++) begin
				mem[i] <= {OP_JMP, 12'(i), 1'b0}; // every word jumps to itself
			end
		end else if (loadEn) begin
			mem[loadAddr[12:1]] <= loadData;
		end else begin
			if (WR0_BUF) begin
				mem[ADDR_BUF[12:1]][7:0] <= DOUT_BUF[7:0];
			end
			if (WR1_BUF) begin
				mem[ADDR_BUF[12:1]][15:8] <= DOUT_BUF[15:8];
			end
		end
	end

	task automatic compareValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic pushEvent(input logic [15:0] addr, input logic rd, input logic wr0,
			input logic wr1, input logic [15:0] data, input logic [15:0] mask);
		busEventT e;
		e = '{addr, rd, wr0, wr1, data, mask};
		expQ.push_back(e);
	endtask

	// executes one instruction by the opcode rules and queues the pin cycles it implies
	task automatic modelStep();
		logic [15:0] instr;
		logic [15:0] arg;
		opcodeT      op;
		instr = mDebug ? mOpcode : shadow[mPc[12:1]];
		if (!mDebug) begin
			pushEvent(mPc, 1'b1, 1'b0, 1'b0, 16'h0000, 16'h0000);
		end
		arg = {3'b000, instr[12:0]};
		op  = opcodeT'(instr[15:13]);
		case (op)
			OP_LDW: begin
				if (!mDebug) begin
					pushEvent(arg, 1'b1, 1'b0, 1'b0, 16'h0000, 16'h0000);
				end
				mAcc = mDebug ? mArg : shadow[arg[12:1]];
			end
			OP_STW: begin
				if (mDebug) begin
					mArg = mAcc;
				end else begin
					shadow[arg[12:1]] = mAcc;
					pushEvent(arg, 1'b0, 1'b1, 1'b1, mAcc, 16'hffff);
				end
			end
			OP_STB: begin
				if (mDebug) begin
					mArg = mAcc; // the port captures the whole accumulator
				end else if (arg[0]) begin
					shadow[arg[12:1]][15:8] = mAcc[7:0];
					pushEvent(arg, 1'b0, 1'b0, 1'b1, {mAcc[7:0], 8'h00}, 16'hff00);
				end else begin
					shadow[arg[12:1]][7:0] = mAcc[7:0];
					pushEvent(arg, 1'b0, 1'b1, 1'b0, mAcc, 16'h00ff);
				end
			end
			OP_LDI: begin
				mAcc = arg;
			end
			default: begin
			end
		endcase
		mPc = (op == OP_JMP) ? arg : mPc + 16'd2;
	endtask

	// matches a strobed pin cycle against the head of the expected queue
	task automatic checkBusCycle();
		busEventT e;
		if (RD_BUF || WR0_BUF || WR1_BUF) begin
			if (expQ.size() == 0) begin
				errorCount++;
				$display("unexpected bus cycle at address 0x%h", ADDR_BUF);
			end else begin
				e = expQ.pop_front();
				compareValue("ADDR_BUF", ADDR_BUF, e.addr);
				compareValue("RD_BUF", 16'(RD_BUF), 16'(e.rd));
				compareValue("WR0_BUF", 16'(WR0_BUF), 16'(e.wr0));
				compareValue("WR1_BUF", 16'(WR1_BUF), 16'(e.wr1));
				compareValue("DOUT_BUF", DOUT_BUF & e.mask, e.data & e.mask);
			end
		end
	endtask

	task automatic writeHost(input hostRegT r, input logic [15:0] d);
		@(posedge CLK);
		hostWrite <= 1'b1;
		hostReg   <= r;
		hostWdata <= d;
		@(posedge CLK);
		hostWrite <= 1'b0;
	endtask

	task automatic flagTimeout(input string what);
		$display("timed out waiting for %s", what);
		timedOut = 1'b1;
	endtask

	// polls the idle bit of HOST_CTRL until it equals wantIdle
	task automatic waitIdle(input logic wantIdle, input bit watchBus, input string what);
		int n;
		@(posedge CLK);
		hostReg <= HOST_CTRL;
		for (n = 0; n < 200; n++) begin
			@(negedge CLK);
			if (watchBus) begin
				checkBusCycle();
				if (mDebug && !hostRdata[CTRL_IDLE_BIT]) begin
					compareValue("ADDR_BUF", ADDR_BUF, mAddr); // pins show the debug address
				end
			end
			if (hostRdata[CTRL_IDLE_BIT] == wantIdle) begin
				break;
			end
		end
		if (n == 200) begin
			flagTimeout(what);
		end
	endtask

	task automatic drainEvents(input string what);
		int n;
		for (n = 0; n < 200; n++) begin
			@(negedge CLK);
			checkBusCycle();
			if (expQ.size() == 0) begin
				break;
			end
		end
		if (n == 200) begin
			flagTimeout(what);
		end
	endtask

	task automatic applyRow(input rowT r);
		logic [31:0] rv;
		logic [15:0] d;
		logic [15:0] exp;
		int          n;
		rv = $urandom();
		d  = r.rnd ? rv[15:0] : r.data;
		case (r.kind)
			K_LOAD: begin
				shadow[r.addr[12:1]] = d;
				@(posedge CLK);
				loadEn   <= 1'b1;
				loadAddr <= r.addr;
				loadData <= d;
				@(posedge CLK);
				loadEn <= 1'b0;
			end
			K_HWR: begin
				writeHost(r.hreg, d);
				case (r.hreg)
					HOST_CTRL: begin
						mStop  = d[CTRL_STOP_BIT];
						mDebug = d[CTRL_DEBUG_BIT];
					end
					HOST_OPCODE: mOpcode = d;
					HOST_ARG:    mArg = d;
					default:     mAddr = d;
				endcase
			end
			K_RUNTO: begin
				mStop  = 1'b0;
				mDebug = 1'b0;
				for (n = 0; n < 64 && mPc != r.addr; n++) begin
					modelStep();
				end
				if (mPc != r.addr) begin
					$display("program never reaches 0x%h", r.addr);
					timedOut = 1'b1;
				end else begin
					pushEvent(r.addr, 1'b1, 1'b0, 1'b0, 16'h0000, 16'h0000); // loop fetch
					writeHost(HOST_CTRL, 16'h0000);
					drainEvents("the run to its end address");
				end
			end
			K_STOP: begin
				mStop = 1'b1;
				writeHost(HOST_CTRL, {14'b0, mDebug, 1'b1});
				waitIdle(1'b1, 1'b0, "the ring to park after stop");
			end
			K_STEP: begin
				modelStep();
				writeHost(HOST_CTRL, {13'b0, 1'b1, mDebug, 1'b1});
				waitIdle(1'b0, 1'b1, "a step to start");
				waitIdle(1'b1, 1'b1, "a step to finish");
				if (expQ.size() != 0) begin
					errorCount++;
					$display("step ended with %0d expected bus cycles missing", expQ.size());
					expQ.delete();
				end
			end
			K_QUIET: begin
				for (n = 0; n < int'(r.data); n++) begin
					@(negedge CLK);
					checkBusCycle(); // queue is empty so any strobe is reported
				end
			end
			K_EXPMEM: begin
				@(negedge CLK);
				compareValue($sformatf("mem[0x%h]", r.addr), mem[r.addr[12:1]],
					shadow[r.addr[12:1]]);
			end
			default: begin
				@(posedge CLK);
				hostReg <= r.hreg;
				@(negedge CLK);
				case (r.hreg)
					HOST_CTRL:   exp = {12'b0, 1'b1, 1'b0, mDebug, mStop}; // parked
					HOST_OPCODE: exp = mOpcode;
					HOST_ARG:    exp = mArg;
					default:     exp = mAddr;
				endcase
				compareValue("hostRdata", hostRdata, exp);
			end
		endcase
	endtask

	initial begin
		int row;
		int curTest;
		int testErrors;
		int testCount;
		RESET     <= 1'b1;
		hostWrite <= 1'b0;
		hostReg   <= HOST_CTRL;
		hostWdata <= 16'h0000;
		loadEn    <= 1'b0;
		loadAddr  <= 16'h0000;
		loadData  <= 16'h0000;
		void'($urandom(32'hda97c05d));
		for (int i = 0; i < 4096; i++) begin
			shadow[i] = {OP_JMP, 12'(i), 1'b0};
		end
		mPc        = 16'h0000;
		mAcc       = 16'h0000;
		mOpcode    = 16'h0000;
		mArg       = 16'h0000;
		mAddr      = 16'h0000;
		mStop      = 1'b0;
		mDebug     = 1'b0;
		checkCount = 0;
		errorCount = 0;
		timedOut   = 1'b0;

		// reset state, strobes stay low until the first DECODE
		@(posedge CLK);
		@(negedge CLK);
		compareValue("RD_BUF", 16'(RD_BUF), 16'h0000);
		@(posedge CLK);
		RESET <= 1'b0;
		@(negedge CLK); // FETCH
		compareValue("RD_BUF", 16'(RD_BUF), 16'h0000);
		compareValue("WR0_BUF", 16'(WR0_BUF), 16'h0000);
		compareValue("WR1_BUF", 16'(WR1_BUF), 16'h0000);
		compareValue("hostRdata", hostRdata & 16'h0003, 16'h0000);
		@(negedge CLK); // DECODE
		compareValue("RD_BUF", 16'(RD_BUF), 16'h0001);
		compareValue("ADDR_BUF", ADDR_BUF, 16'h0000);
		$display("test 1 finished with %0d errors", errorCount);
		testCount  = 1;
		curTest    = int'(PROGRAM_TABLE[0].test);
		testErrors = errorCount;

		row = 0;
		while (row < ROW_COUNT && !timedOut) begin
			if (int'(PROGRAM_TABLE[row].test) != curTest) begin
				$display("test %0d finished with %0d errors", curTest, errorCount - testErrors);
				testCount++;
				curTest    = int'(PROGRAM_TABLE[row].test);
				testErrors = errorCount;
			end
			applyRow(PROGRAM_TABLE[row]);
			row++;
		end
		$display("test %0d finished with %0d errors%s", curTest, errorCount - testErrors,
			timedOut ? " after a timeout" : "");
		testCount++;

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0 && !timedOut) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+verif
logic/cpuPkg.sv
logic/coreSequencer.sv
logic/busInterface.sv
logic/debugPort.sv
logic/cpuSubsystem.sv
verif/cpuSubsystemTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpuSubsystemTb -f project.f \
	-Mdir obj_dir -o cpuSubsystemTb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/cpuSubsystemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
	exit 0
fi
exit 1
